// ==== hw/router_pkg.sv ====
package router_pkg;

  // byte path
  localparam int data_w = 8;
  localparam int addr_w = 2;
  localparam int num_ports = 3;

  // output fifo geometry
  localparam int fifo_depth = 16;
  localparam int ptr_w = $clog2(fifo_depth);

  // idle read limit before a port is flushed
  localparam int soft_rst_cycles = 30;

  typedef logic [data_w-1:0] byte_t;

  // controller states, encoded 0 to 7 in this order
  typedef enum logic [2:0] {
    decode_address,
    load_first_data,
    load_data,
    wait_till_empty,
    check_parity_error,
    load_parity,
    fifo_full_state,
    load_after_full
  } state_t;

endpackage

// ==== hw/router_fsm.sv ====
`timescale 1ns/1ps

module router_fsm (
  input  logic                          clk,
  input  logic                          rst,
  input  logic                          pkt_valid,
  input  logic [router_pkg::addr_w-1:0] data_in_addr,
  input  logic                          fifo_full,
  input  logic                          fifo_empty_0,
  input  logic                          fifo_empty_1,
  input  logic                          fifo_empty_2,
  input  logic                          soft_rst_0,
  input  logic                          soft_rst_1,
  input  logic                          soft_rst_2,
  input  logic                          parity_done,
  input  logic                          low_pkt_valid,
  output logic                          write_enb_reg,
  output logic                          detect_addr,
  output logic                          ld_state,
  output logic                          laf_state,
  output logic                          lfd_state,
  output logic                          full_state,
  output logic                          rst_int_reg,
  output logic                          busy
);
  import router_pkg::*;

  state_t state;
  state_t next_state;
  logic [addr_w-1:0] addr_q;
  logic [addr_w-1:0] sel_addr;
  logic tgt_empty;
  logic any_soft_rst;

  assign any_soft_rst = soft_rst_0 || soft_rst_1 || soft_rst_2;

  always_ff @(posedge clk) begin
    if (!rst || any_soft_rst) begin
      state <= decode_address;
    end else begin
      state <= next_state;
    end
  end

  // header address, held for the wait state
  always_ff @(posedge clk) begin
    if (!rst) begin
      addr_q <= '0;
    end else if (state == decode_address) begin
      addr_q <= data_in_addr;
    end
  end

  // empty flag of the addressed port only
  always_comb begin
    sel_addr = (state == decode_address) ? data_in_addr : addr_q;
    case (sel_addr)
      2'd0:    tgt_empty = fifo_empty_0;
      2'd1:    tgt_empty = fifo_empty_1;
      2'd2:    tgt_empty = fifo_empty_2;
      default: tgt_empty = 1'b0;
    endcase
  end

  always_comb begin
    next_state = state;
    case (state)
      decode_address: begin
        if (pkt_valid && int'(data_in_addr) < num_ports) begin
          next_state = tgt_empty ? load_first_data : wait_till_empty;
        end
      end
      load_first_data: next_state = load_data;
      load_data: begin
        if (fifo_full) begin
          next_state = fifo_full_state;
        end else if (!pkt_valid) begin
          next_state = load_parity;
        end
      end
      wait_till_empty: begin
        if (tgt_empty) begin
          next_state = load_first_data;
        end
      end
      load_parity: next_state = fifo_full ? fifo_full_state : check_parity_error;
      fifo_full_state: begin
        if (!fifo_full) begin
          next_state = load_after_full;
        end
      end
      load_after_full: begin
        // parity byte already out means the packet is complete
        if (parity_done) begin
          next_state = check_parity_error;
        end else if (low_pkt_valid) begin
          next_state = load_parity;
        end else begin
          next_state = load_data;
        end
      end
      check_parity_error: next_state = decode_address;
      default: next_state = decode_address;
    endcase
  end

  assign detect_addr   = (state == decode_address);
  assign lfd_state     = (state == load_first_data);
  assign ld_state      = (state == load_data);
  assign laf_state     = (state == load_after_full);
  assign full_state    = (state == fifo_full_state);
  assign rst_int_reg   = (state == check_parity_error);
  assign write_enb_reg = ld_state || laf_state || (state == load_parity);
  assign busy          = !(detect_addr || ld_state);

  a_state_legal: assert property (@(posedge clk) disable iff (!rst)
    !$isunknown(state) && state inside {decode_address, load_first_data, load_data,
      wait_till_empty, check_parity_error, load_parity, fifo_full_state, load_after_full})
    else $error("router_fsm: illegal state %0d", state);

endmodule

// ==== hw/router_reg.sv ====
`timescale 1ns/1ps

module router_reg (
  input  logic              clk,
  input  logic              rst,
  input  router_pkg::byte_t data_in,
  input  logic              pkt_valid,
  input  logic              fifo_full,
  input  logic              detect_addr,
  input  logic              ld_state,
  input  logic              laf_state,
  input  logic              lfd_state,
  input  logic              full_state,
  input  logic              rst_int_reg,
  output logic              parity_done,
  output logic              low_pkt_valid,
  output logic              err,
  output router_pkg::byte_t dout
);
  import router_pkg::*;

  byte_t header;
  byte_t full_byte;
  byte_t int_parity;
  byte_t pkt_parity;

  always_ff @(posedge clk) begin
    if (detect_addr && pkt_valid) begin
      header <= data_in;
    end
  end

  // byte headed for the fifo
  always_ff @(posedge clk) begin
    if (!rst) begin
      dout <= '0;
    end else if (lfd_state) begin
      dout <= header;
    end else if (ld_state && !fifo_full) begin
      dout <= data_in;
    end else if (laf_state) begin
      dout <= full_byte;
    end
  end

  // byte accepted while the fifo was full
  always_ff @(posedge clk) begin
    if (ld_state && fifo_full) begin
      full_byte <= data_in;
    end
  end

  always_ff @(posedge clk) begin
    if (lfd_state) begin
      int_parity <= header;
    end else if (ld_state && pkt_valid && !full_state) begin
      int_parity <= int_parity ^ data_in;
    end
  end

  // received parity byte
  always_ff @(posedge clk) begin
    if (ld_state && !pkt_valid) begin
      pkt_parity <= data_in;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst || detect_addr) begin
      low_pkt_valid <= 1'b0;
      parity_done   <= 1'b0;
    end else begin
      if (ld_state && !pkt_valid) begin
        low_pkt_valid <= 1'b1;
      end
      if ((ld_state && !fifo_full && !pkt_valid) || (laf_state && low_pkt_valid)) begin
        parity_done <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!rst || lfd_state) begin
      err <= 1'b0;
    end else if (rst_int_reg) begin
      err <= (int_parity != pkt_parity);
    end
  end

  a_err_rise: assert property (@(posedge clk) disable iff (!rst)
    $rose(err) |-> $past(rst_int_reg))
    else $error("router_reg: err rose outside the parity check");

endmodule

// ==== hw/router_sync.sv ====
`timescale 1ns/1ps

module router_sync (
  input  logic                             clk,
  input  logic                             rst,
  input  logic                             detect_addr,
  input  logic [router_pkg::addr_w-1:0]    data_in_addr,
  input  logic                             write_enb_reg,
  input  logic                             read_enb_0,
  input  logic                             read_enb_1,
  input  logic                             read_enb_2,
  input  logic                             empty_0,
  input  logic                             empty_1,
  input  logic                             empty_2,
  input  logic                             full_0,
  input  logic                             full_1,
  input  logic                             full_2,
  output logic                             fifo_full,
  output logic [router_pkg::num_ports-1:0] write_enb,
  output logic                             vld_out_0,
  output logic                             vld_out_1,
  output logic                             vld_out_2,
  output logic                             soft_rst_0,
  output logic                             soft_rst_1,
  output logic                             soft_rst_2
);
  import router_pkg::*;

  logic [addr_w-1:0] addr_q;
  logic [num_ports-1:0] empty;
  logic [num_ports-1:0] full;
  logic [num_ports-1:0] rd;
  logic [num_ports-1:0] vld;
  logic [num_ports-1:0] srst;

  assign empty = {empty_2, empty_1, empty_0};
  assign full  = {full_2, full_1, full_0};
  assign rd    = {read_enb_2, read_enb_1, read_enb_0};
  assign vld   = ~empty;

  assign vld_out_0  = vld[0];
  assign vld_out_1  = vld[1];
  assign vld_out_2  = vld[2];
  assign soft_rst_0 = srst[0];
  assign soft_rst_1 = srst[1];
  assign soft_rst_2 = srst[2];

  always_ff @(posedge clk) begin
    if (!rst) begin
      addr_q <= '0;
    end else if (detect_addr && int'(data_in_addr) < num_ports) begin
      addr_q <= data_in_addr;
    end
  end

  // steer writes to the latched port, hold them off while it is full
  always_comb begin
    fifo_full = 1'b0;
    write_enb = '0;
    for (int i = 0; i < num_ports; i++) begin
      if (int'(addr_q) == i) begin
        fifo_full    = full[i];
        write_enb[i] = write_enb_reg && !full[i];
      end
    end
  end

  for (genvar i = 0; i < num_ports; i++) begin : g_timer
    logic [4:0] idle_cnt;
    logic       pulse;

    always_ff @(posedge clk) begin
      if (!rst) begin
        idle_cnt <= '0;
        pulse    <= 1'b0;
      end else if (vld[i] && !rd[i]) begin
        pulse    <= (idle_cnt == 5'(soft_rst_cycles - 1));
        idle_cnt <= (idle_cnt == 5'(soft_rst_cycles - 1)) ? '0 : idle_cnt + 1'b1;
      end else begin
        idle_cnt <= '0;
        pulse    <= 1'b0;
      end
    end

    assign srst[i] = pulse;
  end

  a_wr_onehot: assert property (@(posedge clk) disable iff (!rst) $onehot0(write_enb))
    else $error("router_sync: more than one fifo written");

endmodule

// ==== hw/router_fifo.sv ====
`timescale 1ns/1ps

module router_fifo (
  input  logic              clk,
  input  logic              rst,
  input  logic              soft_rst,
  input  logic              write_enb,
  input  logic              read_enb,
  input  router_pkg::byte_t data_in,
  output router_pkg::byte_t data_out,
  output logic              empty,
  output logic              full
);
  import router_pkg::*;

  byte_t mem [fifo_depth];
  logic [ptr_w-1:0] wr_ptr;
  logic [ptr_w-1:0] rd_ptr;
  logic [ptr_w:0] count;
  logic do_wr;
  logic do_rd;

  assign empty = (count == '0);
  assign full  = (count == (ptr_w + 1)'(fifo_depth));
  assign do_wr = write_enb && !full;
  assign do_rd = read_enb && !empty;

  always_ff @(posedge clk) begin
    if (do_wr) begin
      mem[wr_ptr] <= data_in;
    end
  end

  // pointers wrap at the depth
  always_ff @(posedge clk) begin
    if (!rst || soft_rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_wr) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (do_rd) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({do_wr, do_rd})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (!rst || soft_rst) begin
      data_out <= '0;
    end else if (do_rd) begin
      data_out <= mem[rd_ptr];
    end
  end

  a_no_wr_full: assert property (@(posedge clk) disable iff (!rst) write_enb |-> !full)
    else $error("router_fifo: write while full");

  // an empty fifo has its read pointer caught up with the write pointer
  a_no_rd_empty: assert property (@(posedge clk) disable iff (!rst)
    empty |-> (rd_ptr == wr_ptr))
    else $error("router_fifo: read pointer passed the write pointer");

endmodule

// ==== hw/router_top.sv ====
`timescale 1ns/1ps

module router_top (
  input  logic              clk,
  input  logic              rst,
  input  router_pkg::byte_t data_in,
  input  logic              pkt_valid,
  input  logic              read_enb_0,
  input  logic              read_enb_1,
  input  logic              read_enb_2,
  output router_pkg::byte_t data_out_0,
  output router_pkg::byte_t data_out_1,
  output router_pkg::byte_t data_out_2,
  output logic              vld_out_0,
  output logic              vld_out_1,
  output logic              vld_out_2,
  output logic              err,
  output logic              busy
);
  import router_pkg::*;

  byte_t dout;
  byte_t fifo_dout [num_ports];
  logic [num_ports-1:0] write_enb;
  logic [num_ports-1:0] empty;
  logic [num_ports-1:0] full;
  logic [num_ports-1:0] soft_rst;
  logic [num_ports-1:0] read_enb;
  logic fifo_full;
  logic parity_done;
  logic low_pkt_valid;
  logic detect_addr;
  logic ld_state;
  logic laf_state;
  logic lfd_state;
  logic full_state;
  logic rst_int_reg;
  logic write_enb_reg;

  assign read_enb   = {read_enb_2, read_enb_1, read_enb_0};
  assign data_out_0 = fifo_dout[0];
  assign data_out_1 = fifo_dout[1];
  assign data_out_2 = fifo_dout[2];

  router_fsm i_router_fsm (
    .data_in_addr(data_in[addr_w-1:0]),
    .fifo_empty_0(empty[0]), .fifo_empty_1(empty[1]), .fifo_empty_2(empty[2]),
    .soft_rst_0(soft_rst[0]), .soft_rst_1(soft_rst[1]), .soft_rst_2(soft_rst[2]),
    .*
  );

  router_reg i_router_reg (.*);

  router_sync i_router_sync (
    .data_in_addr(data_in[addr_w-1:0]),
    .empty_0(empty[0]), .empty_1(empty[1]), .empty_2(empty[2]),
    .full_0(full[0]), .full_1(full[1]), .full_2(full[2]),
    .soft_rst_0(soft_rst[0]), .soft_rst_1(soft_rst[1]), .soft_rst_2(soft_rst[2]),
    .*
  );

  for (genvar i = 0; i < num_ports; i++) begin : g_fifo
    router_fifo i_router_fifo (
      .clk(clk), .rst(rst), .soft_rst(soft_rst[i]),
      .write_enb(write_enb[i]), .read_enb(read_enb[i]), .data_in(dout),
      .data_out(fifo_dout[i]), .empty(empty[i]), .full(full[i])
    );
  end

endmodule

// ==== dv/router_tb.sv ====
`timescale 1ns/1ps

module router_tb;
  import router_pkg::*;

  localparam int num_pkts = 60;
  localparam int timeout_cycles = num_pkts * (63 + 40) * 2;

  logic clk = 1'b0;
  logic rst = 1'b0;
  byte_t data_in = '0;
  logic pkt_valid = 1'b0;
  logic [num_ports-1:0] read_enb = '0;
  byte_t data_out [num_ports];
  logic [num_ports-1:0] vld_out;
  logic err;
  logic busy;

  logic [num_ports-1:0] hold_rd = '0;
  logic [num_ports-1:0] pending = '0;
  int idle_run [num_ports];
  int bytes_taken = 0;
  int cycle_cnt = 0;

  // expected bytes per output port
  byte_t model_0 [$];
  byte_t model_1 [$];
  byte_t model_2 [$];

  always #2 clk = ~clk;

  router_top i_router_top (
    .clk(clk),
    .rst(rst),
    .data_in(data_in),
    .pkt_valid(pkt_valid),
    .read_enb_0(read_enb[0]),
    .read_enb_1(read_enb[1]),
    .read_enb_2(read_enb[2]),
    .data_out_0(data_out[0]),
    .data_out_1(data_out[1]),
    .data_out_2(data_out[2]),
    .vld_out_0(vld_out[0]),
    .vld_out_1(vld_out[1]),
    .vld_out_2(vld_out[2]),
    .err(err),
    .busy(busy)
  );

  task automatic abort_run();
    $display("SIMULATION FAILED");
    $fatal(1, "run stopped at the first failure");
  endtask

  task automatic check_byte(input byte_t got, input byte_t exp, input int port);
    if (got !== exp) begin
      $display("[ERROR] t=%0t port %0d data_out 0x%02h, expected 0x%02h", $time, port, got, exp);
      abort_run();
    end
  endtask

  task automatic check_err(input logic got, input logic exp);
    if (got !== exp) begin
      $display("[ERROR] t=%0t err %b, expected %b", $time, got, exp);
      abort_run();
    end
  endtask

  task automatic check_level(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("[ERROR] t=%0t %s %b, expected %b", $time, name, got, exp);
      abort_run();
    end
  endtask

  function automatic void model_push(input int port, input byte_t b);
    case (port)
      0:       model_0.push_back(b);
      1:       model_1.push_back(b);
      default: model_2.push_back(b);
    endcase
  endfunction

  function automatic byte_t model_pop(input int port);
    case (port)
      0:       return model_0.pop_front();
      1:       return model_1.pop_front();
      default: return model_2.pop_front();
    endcase
  endfunction

  function automatic int model_size(input int port);
    case (port)
      0:       return model_0.size();
      1:       return model_1.size();
      default: return model_2.size();
    endcase
  endfunction

  function automatic void model_clear(input int port);
    case (port)
      0:       model_0.delete();
      1:       model_1.delete();
      default: model_2.delete();
    endcase
  endfunction

  // byte counts as taken on an edge where busy was low
  task automatic send_byte(input byte_t b, input logic valid);
    logic taken;
    data_in   <= b;
    pkt_valid <= valid;
    taken = 1'b0;
    while (!taken) begin
      @(negedge clk);
      taken = !busy;
      @(posedge clk);
    end
    bytes_taken++;
  endtask

  task automatic send_packet(input int port, input int len, input logic bad_parity);
    byte_t hdr;
    byte_t b;
    byte_t par;
    hdr = {len[5:0], port[1:0]};
    par = hdr;
    send_byte(hdr, 1'b1);
    model_push(port, hdr);
    for (int i = 0; i < len; i++) begin
      b = byte_t'($urandom);
      par = par ^ b;
      send_byte(b, 1'b1);
      model_push(port, b);
    end
    if (bad_parity) begin
      par = par ^ byte_t'($urandom_range(255, 1));
    end
    send_byte(par, 1'b0);
    model_push(port, par);
    data_in   <= '0;
    pkt_valid <= 1'b0;
    // err settles two cycles after the parity byte
    repeat (2) @(posedge clk);
    @(negedge clk);
    check_err(err, bad_parity);
    @(posedge clk);
  endtask

  task automatic wait_drain();
    @(negedge clk);
    while (model_size(0) + model_size(1) + model_size(2) != 0 || vld_out != '0) begin
      @(negedge clk);
    end
    @(posedge clk);
  endtask

  always @(posedge clk) begin
    for (int p = 0; p < num_ports; p++) begin
      if (hold_rd[p]) begin
        read_enb[p] <= 1'b0;
      end else begin
        // a port left unread for a few cycles is always read
        read_enb[p] <= (idle_run[p] >= 3) || ($urandom_range(99) < 70);
      end
    end
  end

  always @(negedge clk) begin
    for (int p = 0; p < num_ports; p++) begin
      if (pending[p]) begin
        pending[p] = 1'b0;
        if (model_size(p) == 0) begin
          $display("port %0d delivered a byte that was never sent", p);
          abort_run();
        end else begin
          check_byte(data_out[p], model_pop(p), p);
        end
      end
      // fifo pops at the next edge when both are high
      pending[p] = rst && read_enb[p] && vld_out[p];
      if (vld_out[p] === 1'b1 && !read_enb[p]) begin
        idle_run[p] = idle_run[p] + 1;
      end else begin
        idle_run[p] = 0;
      end
    end
  end

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= timeout_cycles) begin
      $display("timeout: test did not finish within %0d cycles", timeout_cycles);
      abort_run();
    end
  end

  initial begin
    int port;
    int len;
    int wait_cnt;
    int taken0;
    logic bad;
    void'($urandom(32'hb222_7393));
    repeat (16) @(posedge clk);
    rst <= 1'b1;
    @(negedge clk);
    check_level("busy", busy, 1'b0);
    check_err(err, 1'b0);
    for (int p = 0; p < num_ports; p++) begin
      check_level("vld_out", vld_out[p], 1'b0);
    end
    @(posedge clk);

    // random packets to all ports, some with bad parity
    for (int k = 0; k < num_pkts - 4; k++) begin
      port = $urandom_range(num_ports - 1);
      len = $urandom_range(14, 1);
      bad = ($urandom_range(99) < 25);
      send_packet(port, len, bad);
    end
    wait_drain();

    // second packet waits until the first is read out
    port = $urandom_range(num_ports - 1);
    hold_rd[port] <= 1'b1;
    send_packet(port, 4, 1'b0);
    taken0 = bytes_taken;
    fork
      send_packet(port, $urandom_range(10, 1), 1'b0);
      begin
        while (bytes_taken == taken0) begin
          @(negedge clk);
        end
        repeat (8) begin
          @(negedge clk);
          check_level("busy", busy, 1'b1);
        end
        if (bytes_taken != taken0 + 1) begin
          $display("payload was taken while the target fifo still held data");
          abort_run();
        end
        hold_rd[port] <= 1'b0;
      end
    join
    wait_drain();

    // unread port gets flushed
    port = $urandom_range(num_ports - 1);
    hold_rd[port] <= 1'b1;
    send_packet(port, $urandom_range(14, 1), 1'b0);
    @(negedge clk);
    check_level("vld_out", vld_out[port], 1'b1);
    wait_cnt = 0;
    while (vld_out[port] && wait_cnt <= soft_rst_cycles) begin
      @(negedge clk);
      wait_cnt++;
    end
    if (vld_out[port]) begin
      $display("port %0d was not flushed after %0d unread cycles", port, wait_cnt);
      abort_run();
    end
    model_clear(port);
    @(posedge clk);
    hold_rd[port] <= 1'b0;
    send_packet(port, $urandom_range(14, 1), $urandom_range(99) < 25);
    wait_drain();

    if (model_size(0) + model_size(1) + model_size(2) == 0) begin
      $display("SIMULATION PASSED");
      $finish;
    end else begin
      $display("model still holds bytes that never came out");
      abort_run();
    end
  end

endmodule

// ==== tb.f ====
hw/router_pkg.sv
hw/router_fsm.sv
hw/router_reg.sv
hw/router_sync.sv
hw/router_fifo.sv
hw/router_top.sv
dv/router_tb.sv

// ==== Bender.yml ====
package:
  name: router

sources:
  - hw/router_pkg.sv
  - hw/router_fsm.sv
  - hw/router_reg.sv
  - hw/router_sync.sv
  - hw/router_fifo.sv
  - hw/router_top.sv
  - target: test
    files:
      - dv/router_tb.sv
